/* d_cache.f */
cache_geom_pkg.sv
cache_bus_pkg.sv
cache_bank.sv
tag_store.sv
data_store.sv
miss_ctrl.sv
d_cache.sv
cache_checker.sv
tb_d_cache.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the data cache simulation with Verilator

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_d_cache \
	-f d_cache.f -o sim_d_cache
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_d_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

/* tb_d_cache.sv */
// Data cache testbench
`timescale 1ns/1ps

module tb_d_cache
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
;
	localparam int NUM_STEPS = 12;
	localparam int MAX_CYCLES = NUM_STEPS * 40;

	typedef struct packed {
		logic        write;
		logic [15:0] addr;
		logic [31:0] data;
		logic        exp_hit;
		logic        exp_flush;
		logic [15:0] flush_addr;
	} step_t;

	logic        clk;
	logic        rst_n;
	cpu_req_t    i_req;
	cpu_req_t    req_q;     // Held request
	cache_addr_u next_addr; // Address of the request after this one
	logic        i_mem_addr_ready;
	logic        i_mem_wready;
	mem_rdata_t  i_mem_rdata;
	cpu_resp_t   o_resp;
	mem_addr_t   o_mem_addr;
	mem_wdata_t  o_mem_wdata;
	logic        exp_hit;
	logic        exp_flush;
	cache_addr_u flush_addr;
	int          errors;
	int          cycles;
	step_t       steps [NUM_STEPS];
	logic [31:0] mem [1 << 14];
	logic [13:0] rd_ptr;
	logic [13:0] wr_ptr;
	int          rd_left;

	d_cache UUT (.*);

	cache_checker u_checker (
		.clk, .rst_n, .i_req, .i_resp (o_resp),
		.i_mem_addr (o_mem_addr), .i_mem_addr_ready,
		.i_mem_wdata (o_mem_wdata), .i_mem_wready,
		.i_exp_hit (exp_hit), .i_exp_flush (exp_flush), .i_flush_addr (flush_addr),
		.o_errors (errors)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Next address goes out only in the response cycle
	always_comb
	begin
		i_req = req_q;
		if (o_resp.valid)
			i_req.addr_next = next_addr;
	end

	// All lines below sit in set 1 except the last one
	task automatic load_table();
		steps[0]  = {1'b0, 16'h0014, 32'h0, 1'b0, 1'b0, 16'h0};     // Cold read miss
		steps[1]  = {1'b0, 16'h0018, 32'h0, 1'b1, 1'b0, 16'h0};
		steps[2]  = {1'b1, 16'h0014, 32'hdeadbeef, 1'b1, 1'b0, 16'h0};
		steps[3]  = {1'b0, 16'h0014, 32'h0, 1'b1, 1'b0, 16'h0};
		steps[4]  = {1'b1, 16'h0094, 32'h11112222, 1'b0, 1'b0, 16'h0}; // Fills way 1
		steps[5]  = {1'b0, 16'h009c, 32'h0, 1'b1, 1'b0, 16'h0};
		steps[6]  = {1'b1, 16'h0118, 32'h33334444, 1'b0, 1'b1, 16'h0010};
		steps[7]  = {1'b0, 16'h0094, 32'h0, 1'b1, 1'b0, 16'h0};
		steps[8]  = {1'b0, 16'h0118, 32'h0, 1'b1, 1'b0, 16'h0};
		steps[9]  = {1'b0, 16'h0010, 32'h0, 1'b0, 1'b1, 16'h0090};
		steps[10] = {1'b0, 16'h0014, 32'h0, 1'b1, 1'b0, 16'h0};     // Data came back from memory
		steps[11] = {1'b0, 16'h0220, 32'h0, 1'b0, 1'b0, 16'h0};
	endtask

	initial
	begin
		cpu_req_t req_v;

		void'($urandom(32'h967b));
		rst_n = 1'b0;
		req_q = '0;
		next_addr = '0;
		i_mem_addr_ready = 1'b0;
		i_mem_wready = 1'b0;
		i_mem_rdata = '0;
		exp_hit = 1'b0;
		exp_flush = 1'b0;
		flush_addr = '0;
		rd_left = 0;
		for (int a = 0; a < (1 << 14); a++)
			mem[a] = 32'h5a00_0000 + a;
		load_table();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		for (int i = 0; i < NUM_STEPS; i++)
		begin
			req_v.valid = 1'b1;
			req_v.write = steps[i].write;
			req_v.addr.flat = steps[i].addr;
			req_v.addr_next.flat = steps[i].addr; // Stall value until the response
			req_v.wdata = steps[i].data;
			req_q <= req_v;
			if (i + 1 < NUM_STEPS)
				next_addr.flat <= steps[i + 1].addr;
			else
				next_addr <= '0;
			exp_hit <= steps[i].exp_hit;
			exp_flush <= steps[i].exp_flush;
			flush_addr.flat <= steps[i].flush_addr;
			@(posedge clk);
			while (!o_resp.valid)
				@(posedge clk);
		end
		req_q <= '0;
		next_addr <= '0;
		repeat (4) @(posedge clk);
		$display("Checks done with %0d errors", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Memory model with random ready
	always @(posedge clk)
	begin
		i_mem_addr_ready <= ($urandom % 3) == 0;
		i_mem_wready     <= ($urandom % 4) != 0;
		if (rd_left > 0)
		begin
			i_mem_rdata <= {1'b1, mem[rd_ptr]};
			rd_ptr  <= rd_ptr + 1'b1;
			rd_left <= rd_left - 1;
		end
		else
			i_mem_rdata <= '0;
		if (rst_n && o_mem_addr.valid && i_mem_addr_ready)
		begin
			if (o_mem_addr.write)
				wr_ptr <= o_mem_addr.addr.flat[15:2];
			else
			begin
				rd_ptr  <= o_mem_addr.addr.flat[15:2];
				rd_left <= LINE_WORDS;
			end
		end
		if (rst_n && o_mem_wdata.valid && i_mem_wready)
		begin
			mem[wr_ptr] <= o_mem_wdata.data;
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles, a request never completed", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial
		cycles = 0;

endmodule

/* cache_checker.sv */
// Cache response checker
`timescale 1ns/1ps

module cache_checker
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  cpu_req_t    i_req,
	input  cpu_resp_t   i_resp,
	input  mem_addr_t   i_mem_addr,
	input  logic        i_mem_addr_ready,
	input  mem_wdata_t  i_mem_wdata,
	input  logic        i_mem_wready,
	input  logic        i_exp_hit,
	input  logic        i_exp_flush,
	input  cache_addr_u i_flush_addr,
	output int          o_errors
);
	logic [DATA_WIDTH-1:0]   shadow [1 << (ADDR_WIDTH - 2)]; // Expected memory contents
	logic                    started;
	logic                    saw_addr;  // Address beat during this request
	logic                    saw_flush;
	logic                    waited;    // Request went past its first cycle
	logic [13:0]             wr_ptr;
	logic [OFFSET_WIDTH-1:0] wr_beat;   // Word position inside a write burst
	logic                    exp_last;

	// Last flag belongs to word 3 of the line
	assign exp_last = wr_beat == OFFSET_WIDTH'(3);

	initial
	begin
		o_errors = 0;
		for (int a = 0; a < (1 << (ADDR_WIDTH - 2)); a++)
			shadow[a] = 32'h5a00_0000 + a; // Same fill rule as memory
	end

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("error %s expected %h got %h", name, exp, got);
		o_errors = o_errors + 1;
	endtask

	task automatic plain_error(input string what);
		$display("%s", what);
		o_errors = o_errors + 1;
	endtask

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			started   <= 1'b0;
			saw_addr  <= 1'b0;
			saw_flush <= 1'b0;
			waited    <= 1'b0;
		end
		else
		begin
			if (i_req.valid)
				started <= 1'b1;
			else if (!started && (i_resp.valid || i_mem_addr.valid || i_mem_wdata.valid))
				plain_error("Output valid went high before the first request");
			if (i_req.valid && !i_resp.valid)
				waited <= 1'b1;
			if (i_mem_addr.valid && i_mem_addr_ready)
			begin
				saw_addr <= 1'b1;
				if (i_mem_addr.write)
				begin
					saw_flush <= 1'b1;
					wr_ptr    <= i_mem_addr.addr.flat[15:2];
					wr_beat   <= '0;
					if (!i_exp_flush)
						plain_error("Write burst started where none was expected");
					else if (i_mem_addr.addr.flat != i_flush_addr.flat)
						value_error("o_mem_addr.addr", i_flush_addr.flat, i_mem_addr.addr.flat);
				end
			end
			if (i_mem_wdata.valid && i_mem_wready)
			begin
				if (i_mem_wdata.data != shadow[wr_ptr])
					value_error("o_mem_wdata.data", shadow[wr_ptr], i_mem_wdata.data);
				if (i_mem_wdata.last != exp_last)
					value_error("o_mem_wdata.last", exp_last, i_mem_wdata.last);
				wr_ptr  <= wr_ptr + 1'b1;
				wr_beat <= wr_beat + 1'b1;
			end
			if (i_resp.valid)
			begin
				if (i_exp_hit && saw_addr)
					plain_error("Request expected to hit went to memory");
				if (i_exp_hit && waited)
					plain_error("Request expected to hit did not answer in its first cycle");
				if (i_exp_flush && !saw_flush)
					plain_error("Expected dirty line flush never happened");
				if (i_req.write)
					shadow[i_req.addr.flat[15:2]] <= i_req.wdata;
				else if (i_resp.rdata != shadow[i_req.addr.flat[15:2]])
					value_error("o_resp.rdata", shadow[i_req.addr.flat[15:2]], i_resp.rdata);
				saw_addr  <= 1'b0;
				saw_flush <= 1'b0;
				waited    <= 1'b0;
			end
		end
	end

endmodule

/* d_cache.sv */
// Two-way write-back data cache
`timescale 1ns/1ps

module d_cache
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  cpu_req_t   i_req,
	input  logic       i_mem_addr_ready,
	input  logic       i_mem_wready,
	input  mem_rdata_t i_mem_rdata,
	output cpu_resp_t  o_resp,
	output mem_addr_t  o_mem_addr,
	output mem_wdata_t o_mem_wdata
);
	logic                                  hit;
	way_t                                  hit_way;
	way_t                                  victim_way;
	logic                                  victim_dirty;
	tag_t                                  victim_tag;
	logic                                  ready_state;
	index_t                                fill_index;
	way_t                                  fill_way;
	tag_t                                  fill_tag;
	logic                                  fill_word;
	logic [DATA_WIDTH-1:0]                 fill_data;
	logic                                  line_done;
	index_t                                raddr_index;
	logic [DATA_WIDTH-1:0]                 rdata;
	logic [LINE_WORDS-1:0][DATA_WIDTH-1:0] victim_line;

	tag_store u_tag_store (
		.clk,
		.rst_n,
		.i_req,
		.i_ready_state  (ready_state),
		.i_fill_index   (fill_index),
		.i_fill_way     (fill_way),
		.i_fill_tag     (fill_tag),
		.i_line_done    (line_done),
		.i_raddr_index  (raddr_index),
		.o_hit          (hit),
		.o_hit_way      (hit_way),
		.o_victim_way   (victim_way),
		.o_victim_dirty (victim_dirty),
		.o_victim_tag   (victim_tag)
	);

	data_store u_data_store (
		.clk,
		.rst_n,
		.i_req,
		.i_hit         (hit),
		.i_hit_way     (hit_way),
		.i_fill_way    (fill_way),
		.i_fill_index  (fill_index),
		.i_fill_word   (fill_word),
		.i_fill_data   (fill_data),
		.i_raddr_index (raddr_index),
		.o_rdata       (rdata),
		.o_line        (victim_line)
	);

	miss_ctrl u_miss_ctrl (
		.clk,
		.rst_n,
		.i_req,
		.i_hit            (hit),
		.i_victim_way     (victim_way),
		.i_victim_dirty   (victim_dirty),
		.i_victim_tag     (victim_tag),
		.i_line           (victim_line),
		.i_mem_addr_ready,
		.i_mem_wready,
		.i_mem_rdata,
		.o_mem_addr,
		.o_mem_wdata,
		.o_ready_state    (ready_state),
		.o_fill_index     (fill_index),
		.o_fill_way       (fill_way),
		.o_fill_tag       (fill_tag),
		.o_fill_word      (fill_word),
		.o_fill_data      (fill_data),
		.o_line_done      (line_done),
		.o_raddr_index    (raddr_index)
	);

	assign o_resp.valid = hit; // Same cycle as the request
	assign o_resp.rdata = rdata;

endmodule

/* miss_ctrl.sv */
// Miss handling and memory bursts
`timescale 1ns/1ps

module miss_ctrl
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  cpu_req_t                              i_req,
	input  logic                                  i_hit,
	input  way_t                                  i_victim_way,
	input  logic                                  i_victim_dirty,
	input  tag_t                                  i_victim_tag,
	input  logic [LINE_WORDS-1:0][DATA_WIDTH-1:0] i_line,
	input  logic                                  i_mem_addr_ready,
	input  logic                                  i_mem_wready,
	input  mem_rdata_t                            i_mem_rdata,
	output mem_addr_t                             o_mem_addr,
	output mem_wdata_t                            o_mem_wdata,
	output logic                                  o_ready_state,
	output index_t                                o_fill_index,
	output way_t                                  o_fill_way,
	output tag_t                                  o_fill_tag,
	output logic                                  o_fill_word,
	output logic [DATA_WIDTH-1:0]                 o_fill_data,
	output logic                                  o_line_done,
	output index_t                                o_raddr_index
);
	typedef enum logic [2:0] {
		ST_READY,
		ST_FLUSH_REQ,   // Write address out
		ST_FLUSH_DATA,  // Dirty line out
		ST_REFILL_REQ,  // Read address out
		ST_REFILL_DATA  // Line coming back
	} state_t;

	state_t                                state_q;
	state_t                                state_d;
	tag_t                                  miss_tag_q;
	index_t                                miss_index_q;
	way_t                                  miss_way_q;
	logic [LINE_WORDS-1:0][DATA_WIDTH-1:0] shift_q;    // Flush words, word 0 first
	logic [OFFSET_WIDTH-1:0]               beat_q;     // Word count inside a burst
	index_t                                rd_index_q; // Set the banks are showing
	logic                                  miss;
	logic                                  last_beat;
	logic                                  wr_beat;

	// Only act on a lookup whose banks hold the requested set
	assign miss = i_req.valid && state_q == ST_READY && !i_hit
		&& rd_index_q == i_req.addr.part.index;

	assign last_beat     = beat_q == OFFSET_WIDTH'(LINE_WORDS - 1);
	assign wr_beat       = o_mem_wdata.valid && i_mem_wready;
	assign o_fill_word   = state_q == ST_REFILL_DATA && i_mem_rdata.valid;
	assign o_line_done   = o_fill_word && last_beat;
	assign o_ready_state = state_q == ST_READY;
	assign o_fill_index  = miss_index_q;
	assign o_fill_way    = miss_way_q;
	assign o_fill_tag    = miss_tag_q;
	assign o_fill_data   = i_mem_rdata.data;

	// Banks follow the next request only while idle
	assign o_raddr_index = o_ready_state ? i_req.addr_next.part.index : miss_index_q;

	always_comb
	begin
		o_mem_addr                  = '0;
		o_mem_addr.valid            = state_q == ST_FLUSH_REQ || state_q == ST_REFILL_REQ;
		o_mem_addr.write            = state_q == ST_FLUSH_REQ;
		o_mem_addr.addr.part.tag    = (state_q == ST_FLUSH_REQ) ? i_victim_tag : miss_tag_q;
		o_mem_addr.addr.part.index  = miss_index_q;
	end

	always_comb
	begin
		o_mem_wdata.valid = state_q == ST_FLUSH_DATA;
		o_mem_wdata.data  = shift_q[0];
		o_mem_wdata.last  = state_q == ST_FLUSH_DATA && last_beat;
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_READY:
				if (miss)
					state_d = i_victim_dirty ? ST_FLUSH_REQ : ST_REFILL_REQ;
			ST_FLUSH_REQ:
				if (i_mem_addr_ready)
					state_d = ST_FLUSH_DATA;
			ST_FLUSH_DATA:
				if (wr_beat && last_beat)
					state_d = ST_REFILL_REQ;
			ST_REFILL_REQ:
				if (i_mem_addr_ready)
					state_d = ST_REFILL_DATA;
			ST_REFILL_DATA:
				if (o_line_done)
					state_d = ST_READY; // Held request hits next cycle
			default:
				state_d = ST_READY;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q    <= ST_READY;
			beat_q     <= '0;
			rd_index_q <= '0;
		end
		else
		begin
			state_q    <= state_d;
			rd_index_q <= o_raddr_index;
			if (wr_beat || o_fill_word)
				beat_q <= beat_q + 1'b1; // Wraps to zero after each burst
		end
	end

	always_ff @(posedge clk)
	begin
		if (miss)
		begin
			miss_tag_q   <= i_req.addr.part.tag;
			miss_index_q <= i_req.addr.part.index;
			miss_way_q   <= i_victim_way;
		end
		if (state_q == ST_FLUSH_REQ && i_mem_addr_ready)
			shift_q <= i_line;
		else if (wr_beat)
			shift_q <= shift_q >> DATA_WIDTH;
	end

	// Address beat holds still until memory takes it
	assert property (@(posedge clk) disable iff (!rst_n)
		o_mem_addr.valid && !i_mem_addr_ready |=> $stable(o_mem_addr));

endmodule

/* data_store.sv */
// Data word banks for both ways
`timescale 1ns/1ps

module data_store
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  cpu_req_t                              i_req,
	input  logic                                  i_hit,
	input  way_t                                  i_hit_way,
	input  way_t                                  i_fill_way,
	input  index_t                                i_fill_index,
	input  logic                                  i_fill_word,
	input  logic [DATA_WIDTH-1:0]                 i_fill_data,
	input  index_t                                i_raddr_index,
	output logic [DATA_WIDTH-1:0]                 o_rdata,
	output logic [LINE_WORDS-1:0][DATA_WIDTH-1:0] o_line
);
	logic [1:0][LINE_WORDS-1:0][DATA_WIDTH-1:0] bank_rdata;
	logic [LINE_WORDS-1:0] word_sel_q; // One-hot refill position
	logic [DATA_WIDTH-1:0] wdata;
	index_t                waddr;
	logic                  write_hit;

	assign write_hit = i_hit && i_req.write;
	assign wdata     = i_fill_word ? i_fill_data : i_req.wdata;
	assign waddr     = i_fill_word ? i_fill_index : i_req.addr.part.index;

	for (genvar w = 0; w < 2; w++)
	begin : g_way
		for (genvar k = 0; k < LINE_WORDS; k++)
		begin : g_word
			logic we;

			assign we = (i_fill_word && i_fill_way == way_t'(w) && word_sel_q[k])
				|| (write_hit && i_hit_way == way_t'(w)
				&& i_req.addr.part.offset == OFFSET_WIDTH'(k)); // Store hits one word

			cache_bank #(
				.DATA_W (DATA_WIDTH),
				.ADDR_W (INDEX_WIDTH)
			) u_data_bank (
				.clk,
				.i_we    (we),
				.i_waddr (waddr),
				.i_wdata (wdata),
				.i_raddr (i_raddr_index),
				.o_rdata (bank_rdata[w][k])
			);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			word_sel_q <= LINE_WORDS'(1);
		else if (i_fill_word)
			word_sel_q <= {word_sel_q[LINE_WORDS-2:0], word_sel_q[LINE_WORDS-1]};
	end

	assign o_rdata = bank_rdata[i_hit_way][i_req.addr.part.offset];
	assign o_line  = bank_rdata[i_fill_way]; // Victim line for the flush

endmodule

/* tag_store.sv */
// Tag banks and line state
`timescale 1ns/1ps

module tag_store
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  cpu_req_t i_req,
	input  logic     i_ready_state,
	input  index_t   i_fill_index,
	input  way_t     i_fill_way,
	input  tag_t     i_fill_tag,
	input  logic     i_line_done,
	input  index_t   i_raddr_index,
	output logic     o_hit,
	output way_t     o_hit_way,
	output way_t     o_victim_way,
	output logic     o_victim_dirty,
	output tag_t     o_victim_tag
);
	localparam int SETS = 1 << INDEX_WIDTH;

	tag_t [1:0]      tag_rdata;
	logic [1:0]      valid_q [SETS]; // Per set, one bit per way
	logic [1:0]      dirty_q [SETS];
	logic [SETS-1:0] lru_q;          // Least recently used way
	index_t          rd_index_q;     // Set the banks are showing
	index_t          req_index;
	logic [1:0]      tag_match;
	logic            lookup_ok;

	assign req_index = i_req.addr.part.index;
	assign lookup_ok = rd_index_q == req_index;

	for (genvar w = 0; w < 2; w++)
	begin : g_way
		cache_bank #(
			.DATA_W (TAG_WIDTH),
			.ADDR_W (INDEX_WIDTH)
		) u_tag_bank (
			.clk,
			.i_we    (i_line_done && i_fill_way == way_t'(w)),
			.i_waddr (i_fill_index),
			.i_wdata (i_fill_tag),
			.i_raddr (i_raddr_index),
			.o_rdata (tag_rdata[w])
		);

		assign tag_match[w] = valid_q[req_index][w] && tag_rdata[w] == i_req.addr.part.tag;
	end

	assign o_hit     = i_req.valid && i_ready_state && lookup_ok && |tag_match;
	assign o_hit_way = tag_match[1];

	// Empty way first, then LRU
	always_comb
	begin
		if (!valid_q[req_index][0])
			o_victim_way = 1'b0;
		else if (!valid_q[req_index][1])
			o_victim_way = 1'b1;
		else
			o_victim_way = lru_q[req_index];
	end

	assign o_victim_dirty = valid_q[req_index][o_victim_way] && dirty_q[req_index][o_victim_way];
	assign o_victim_tag   = tag_rdata[i_fill_way]; // Valid once the missed set is read

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_index_q <= '0;
			lru_q      <= '0;
			for (int s = 0; s < SETS; s++)
			begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end
		else
		begin
			rd_index_q <= i_raddr_index;
			if (o_hit)
			begin
				lru_q[req_index] <= ~o_hit_way;
				if (i_req.write)
					dirty_q[req_index][o_hit_way] <= 1'b1;
			end
			if (i_line_done)
			begin
				lru_q[i_fill_index]               <= ~i_fill_way;
				valid_q[i_fill_index][i_fill_way] <= 1'b1;
				dirty_q[i_fill_index][i_fill_way] <= 1'b0; // Fresh copy of memory
			end
		end
	end

	// Refill must never bring in a line that already sits in the other way
	assert property (@(posedge clk) disable iff (!rst_n)
		i_req.valid && lookup_ok |-> !(&tag_match));

endmodule

/* cache_bank.sv */
// Synchronous-read memory bank
`timescale 1ns/1ps

module cache_bank #(
	parameter int DATA_W = 32,
	parameter int ADDR_W = 3
) (
	input  logic              clk,
	input  logic              i_we,
	input  logic [ADDR_W-1:0] i_waddr,
	input  logic [DATA_W-1:0] i_wdata,
	input  logic [ADDR_W-1:0] i_raddr,
	output logic [DATA_W-1:0] o_rdata
);
	logic [DATA_W-1:0] mem [1 << ADDR_W];
	logic [ADDR_W-1:0] raddr_q; // Held like an SRAM read port

	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
		raddr_q <= i_raddr;
	end

	// A write shows up on the read side one cycle later
	assign o_rdata = mem[raddr_q];

endmodule

/* cache_bus_pkg.sv */
// Processor and memory channel types
package cache_bus_pkg;
	import cache_geom_pkg::*;

	typedef struct packed {
		logic                  valid;
		logic                  write;
		cache_addr_u           addr;
		cache_addr_u           addr_next; // Equals addr while stalled
		logic [DATA_WIDTH-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic                  valid;
		logic [DATA_WIDTH-1:0] rdata;
	} cpu_resp_t;

	// Burst length is always LINE_WORDS
	typedef struct packed {
		logic        valid;
		logic        write; // Flush when set, refill otherwise
		cache_addr_u addr;  // Line aligned
	} mem_addr_t;

	typedef struct packed {
		logic                  valid;
		logic [DATA_WIDTH-1:0] data;
		logic                  last;
	} mem_wdata_t;

	typedef struct packed {
		logic                  valid;
		logic [DATA_WIDTH-1:0] data;
	} mem_rdata_t;

endpackage

/* cache_geom_pkg.sv */
// Cache geometry and address layout
package cache_geom_pkg;

	localparam int ADDR_WIDTH   = 16; // Byte address
	localparam int DATA_WIDTH   = 32;
	localparam int INDEX_WIDTH  = 3;  // Eight sets
	localparam int OFFSET_WIDTH = 2;  // Word within a line
	localparam int LINE_WORDS   = 1 << OFFSET_WIDTH;

	// Two low bits select the byte inside a word
	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;

	typedef logic [INDEX_WIDTH-1:0] index_t;
	typedef logic [TAG_WIDTH-1:0]   tag_t;
	typedef logic                   way_t; // Two ways per set

	// Address fields, high to low
	typedef struct packed {
		tag_t                    tag;
		index_t                  index;
		logic [OFFSET_WIDTH-1:0] offset;
		logic [1:0]              byte_sel;
	} addr_part_t;

	// One address word, read flat or split into fields
	typedef union packed {
		logic [ADDR_WIDTH-1:0] flat;
		addr_part_t            part;
	} cache_addr_u;

endpackage
